// File: logic/debug_pkg.sv
`default_nettype none

package debug_pkg;

  //////////////////////////////////////////////////
  // Link and word geometry.
  //////////////////////////////////////////////////
  localparam int BYTE_WIDTH     = 8;
  localparam int WORD_WIDTH     = 32;
  localparam int BYTES_PER_WORD = 4;

  //////////////////////////////////////////////////
  // Host protocol.
  //////////////////////////////////////////////////
  localparam logic [BYTE_WIDTH-1:0] CMD_LOAD        = 8'h00; // Opens a load session.
  localparam logic [BYTE_WIDTH-1:0] CMD_LOAD_ACK    = 8'h01; // Sent and echoed back.
  localparam logic [BYTE_WIDTH-1:0] CMD_RUN         = 8'h03; // Continuous start.
  localparam logic [BYTE_WIDTH-1:0] CMD_STEP        = 8'h07; // Single step start.
  localparam logic [BYTE_WIDTH-1:0] REPORT_ACK_STEP = 8'd8;  // Ack for byte k is k * 8.
  localparam int                    REPORT_BYTES    = 10;

  localparam logic [WORD_WIDTH-1:0] HALT_WORD = '0; // MIPS HALT opcode.

  // CPU register group read back through the debug data bus.
  typedef enum logic [2:0] {
    sel_none        = 3'd0,
    sel_pc          = 3'd2,
    sel_cycles      = 3'd3,
    sel_adder_pc    = 3'd4,
    sel_instruction = 3'd5
  } db_sel_t;

  typedef enum logic [2:0] {
    st_idle, st_soft_reset, st_send_ack, st_wait_ack,
    st_load, st_wait_start, st_run, st_report
  } seq_state_t;

  typedef union packed {
    logic [WORD_WIDTH-1:0]                     word;
    logic [BYTES_PER_WORD-1:0][BYTE_WIDTH-1:0] bytes; // Byte 3 is the MSB.
  } dbg_word_u;

endpackage

`default_nettype wire

// File: logic/load_if.sv
`timescale 1ns/1ns
`default_nettype none

interface load_if #(
  parameter int PROG_ADDR_WIDTH = 11
) ();
  import debug_pkg::*;

  logic                       active;     // Sequencer is in the load state.
  logic                       byte_valid; // One strobe per received byte.
  logic [BYTE_WIDTH-1:0]      rx_byte;
  logic                       done;       // Zero word seen.
  logic [PROG_ADDR_WIDTH-1:0] word_count; // Words written so far.

  modport sequencer (output active, byte_valid, rx_byte, input done, word_count);
  modport loader (input active, byte_valid, rx_byte, output done, word_count);

endinterface

`default_nettype wire

// File: logic/report_if.sv
`timescale 1ns/1ns
`default_nettype none

interface report_if ();
  import debug_pkg::*;

  logic                  start;      // Run has ended.
  logic                  step_mode;  // Run was a single step.
  logic                  byte_valid; // Host byte during the report.
  logic [BYTE_WIDTH-1:0] rx_byte;
  logic                  done;       // Tenth ack accepted.
  logic                  halted;     // Session is over.

  modport sequencer (
    output start, step_mode, byte_valid, rx_byte,
    input  done, halted
  );
  modport serializer (
    input  start, step_mode, byte_valid, rx_byte,
    output done, halted
  );

endinterface

`default_nettype wire

// File: logic/debug_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module debug_sequencer (
  input  logic                             i_clock,
  input  logic                             i_reset,
  input  logic                             i_rx_done,
  input  logic [debug_pkg::BYTE_WIDTH-1:0] i_rx_data,
  input  logic                             i_soft_reset_ack,
  output logic                             o_soft_reset,
  output logic                             o_ack_start,
  output logic                             o_run_start,
  output logic                             o_step_mode,
  input  logic                             i_run_done,
  load_if.sequencer                        lif,
  report_if.sequencer                      rif
);
  import debug_pkg::*;

  seq_state_t            state;
  logic                  rx_done_q;
  logic                  rx_strobe;
  logic [BYTE_WIDTH-1:0] rx_byte_q;
  logic                  step_q;
  logic                  is_step;
  logic                  start_cmd;

  //////////////////////////////////////////////////
  // Receive edge detection.
  //////////////////////////////////////////////////
  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      rx_done_q <= 1'b0;
      rx_strobe <= 1'b0;
    end else begin
      rx_done_q <= i_rx_done;
      rx_strobe <= rx_done_q & ~i_rx_done; // One cycle after the fall.
    end
  end

  always_ff @(posedge i_clock) begin
    if (rx_done_q && !i_rx_done) begin
      rx_byte_q <= i_rx_data;
    end
  end

  //////////////////////////////////////////////////
  // Session state machine.
  //////////////////////////////////////////////////
  assign is_step   = (rx_byte_q == CMD_STEP);
  assign start_cmd = (state == st_wait_start) && rx_strobe &&
                     ((rx_byte_q == CMD_RUN) || is_step);

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      state  <= st_idle;
      step_q <= 1'b0;
    end else begin
      case (state)
        st_idle: if (rx_strobe && rx_byte_q == CMD_LOAD) state <= st_soft_reset;
        st_soft_reset: if (!i_soft_reset_ack) state <= st_send_ack;
        st_send_ack: state <= st_wait_ack;
        st_wait_ack: if (rx_strobe && rx_byte_q == CMD_LOAD_ACK) state <= st_load;
        st_load: begin
          if (lif.done) begin
            // Nothing to run after an empty program.
            state <= (lif.word_count == '0) ? st_idle : st_wait_start;
          end
        end
        st_wait_start: begin
          if (start_cmd) begin
            state  <= st_run;
            step_q <= is_step;
          end
        end
        st_run: if (i_run_done) state <= st_report;
        st_report: if (rif.done) state <= rif.halted ? st_idle : st_wait_start;
        default: state <= st_idle;
      endcase
    end
  end

  assign o_soft_reset = (state != st_soft_reset); // Active low.
  assign o_ack_start  = (state == st_send_ack);
  assign o_run_start  = start_cmd;
  assign o_step_mode  = start_cmd ? is_step : step_q;

  assign lif.active     = (state == st_load);
  assign lif.byte_valid = (state == st_load) && rx_strobe;
  assign lif.rx_byte    = rx_byte_q;

  assign rif.start      = (state == st_run) && i_run_done;
  assign rif.step_mode  = step_q;
  assign rif.byte_valid = (state == st_report) && rx_strobe;
  assign rif.rx_byte    = rx_byte_q;

  a_no_run_in_load: assert property (@(posedge i_clock) disable iff (!i_reset)
    lif.active |-> !o_run_start);

endmodule

`default_nettype wire

// File: logic/program_loader.sv
`timescale 1ns/1ns
`default_nettype none

module program_loader #(
  parameter int PROG_ADDR_WIDTH = 11
) (
  input  logic                             i_clock,
  input  logic                             i_reset,
  load_if.loader                           lif,
  output logic                             o_prog_we,
  output logic [PROG_ADDR_WIDTH-1:0]       o_prog_addr,
  output logic [debug_pkg::WORD_WIDTH-1:0] o_prog_data
);
  import debug_pkg::*;

  localparam int COUNT_WIDTH = $clog2(BYTES_PER_WORD);

  dbg_word_u                  word_q;
  dbg_word_u                  next_word;
  logic [COUNT_WIDTH-1:0]     count_q; // Byte position in the word.
  logic [PROG_ADDR_WIDTH-1:0] addr_q;

  // MSB arrives first so new bytes enter at the bottom.
  assign next_word.bytes = {word_q.bytes[BYTES_PER_WORD-2:0], lif.rx_byte};

  always_ff @(posedge i_clock) begin
    if (lif.byte_valid) begin
      word_q <= next_word;
    end
  end

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      count_q   <= '0;
      addr_q    <= '0;
      o_prog_we <= 1'b0;
      lif.done  <= 1'b0;
    end else begin
      o_prog_we <= 1'b0;
      lif.done  <= 1'b0;
      if (!lif.active) begin
        count_q <= '0;
        addr_q  <= '0;
      end else if (lif.byte_valid) begin
        count_q <= count_q + 1'b1;
        if (count_q == COUNT_WIDTH'(BYTES_PER_WORD - 1)) begin
          if (next_word.word == HALT_WORD) begin
            lif.done <= 1'b1; // End of program.
          end else begin
            o_prog_we <= 1'b1;
          end
        end
      end
      if (o_prog_we) begin
        addr_q <= addr_q + 1'b1; // Post-increment after the write.
      end
    end
  end

  assign o_prog_addr    = addr_q;
  assign o_prog_data    = word_q.word;
  assign lif.word_count = addr_q;

  a_no_zero_write: assert property (@(posedge i_clock) disable iff (!i_reset)
    o_prog_we |-> o_prog_data != HALT_WORD);

endmodule

`default_nettype wire

// File: logic/report_serializer.sv
`timescale 1ns/1ns
`default_nettype none

module report_serializer (
  input  logic                             i_clock,
  input  logic                             i_reset,
  report_if.serializer                     rif,
  input  logic [debug_pkg::WORD_WIDTH-1:0] i_db_data,
  input  logic [debug_pkg::WORD_WIDTH-1:0] i_instruction,
  output debug_pkg::db_sel_t               o_db_select,
  output logic                             o_tx_start,
  output logic [debug_pkg::BYTE_WIDTH-1:0] o_tx_data
);
  import debug_pkg::*;

  localparam int INDEX_WIDTH = $clog2(REPORT_BYTES + 1);

  logic [INDEX_WIDTH-1:0]            index_q; // Zero when no report runs.
  logic                              first_q; // Select cycle of a byte.
  logic [$clog2(BYTES_PER_WORD)-1:0] byte_pos;
  logic [BYTE_WIDTH-1:0]             ack_expect;
  logic                              ack_ok;
  dbg_word_u                         db_word;

  //////////////////////////////////////////////////
  // Byte index to register group and position.
  //////////////////////////////////////////////////
  always_comb begin
    o_db_select = sel_none;
    byte_pos    = 2'd0;
    case (int'(index_q))
      1:  begin o_db_select = sel_pc;          byte_pos = 2'd1; end
      2:  begin o_db_select = sel_pc;          byte_pos = 2'd0; end
      3:  begin o_db_select = sel_cycles;      byte_pos = 2'd1; end
      4:  begin o_db_select = sel_cycles;      byte_pos = 2'd0; end
      5:  begin o_db_select = sel_adder_pc;    byte_pos = 2'd1; end
      6:  begin o_db_select = sel_adder_pc;    byte_pos = 2'd0; end
      7:  begin o_db_select = sel_instruction; byte_pos = 2'd3; end
      8:  begin o_db_select = sel_instruction; byte_pos = 2'd2; end
      9:  begin o_db_select = sel_instruction; byte_pos = 2'd1; end
      10: begin o_db_select = sel_instruction; byte_pos = 2'd0; end
      default: ;
    endcase
  end

  assign db_word.word = i_db_data;
  assign ack_expect   = BYTE_WIDTH'(index_q) * REPORT_ACK_STEP;
  assign ack_ok       = rif.byte_valid && (index_q != '0) && (rif.rx_byte == ack_expect);

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      index_q    <= '0;
      first_q    <= 1'b0;
      o_tx_start <= 1'b0;
      rif.done   <= 1'b0;
      rif.halted <= 1'b0;
    end else begin
      first_q    <= 1'b0;
      rif.done   <= 1'b0;
      o_tx_start <= first_q; // Send once the select has settled.
      if (rif.start) begin
        index_q <= INDEX_WIDTH'(1);
        first_q <= 1'b1;
      end else if (ack_ok) begin
        if (index_q == INDEX_WIDTH'(REPORT_BYTES)) begin
          index_q    <= '0;
          rif.done   <= 1'b1;
          rif.halted <= !rif.step_mode || (i_instruction == HALT_WORD);
        end else begin
          index_q <= index_q + 1'b1;
          first_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clock) begin
    if (first_q) begin
      o_tx_data <= db_word.bytes[byte_pos];
    end
  end

  a_tx_single: assert property (@(posedge i_clock) disable iff (!i_reset)
    o_tx_start |=> !o_tx_start);

endmodule

`default_nettype wire

// File: logic/run_control.sv
`timescale 1ns/1ns
`default_nettype none

module run_control (
  input  logic                             i_clock,
  input  logic                             i_reset,
  input  logic                             i_start,
  input  logic                             i_step,
  input  logic [debug_pkg::WORD_WIDTH-1:0] i_instruction,
  output logic                             o_enable_pc,
  output logic                             o_done
);
  import debug_pkg::*;

  logic running;
  logic step_q;
  logic fetched_halt;

  assign fetched_halt = (i_instruction == HALT_WORD);

  // A step runs one cycle whatever was fetched.
  assign o_enable_pc = running && (step_q || !fetched_halt);
  assign o_done      = running && (step_q || fetched_halt);

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      running <= 1'b0;
      step_q  <= 1'b0;
    end else if (i_start) begin
      running <= 1'b1;
      step_q  <= i_step;
    end else if (o_done) begin
      running <= 1'b0;
    end
  end

  a_stop_after_done: assert property (@(posedge i_clock) disable iff (!i_reset)
    o_done && !i_start |=> !o_enable_pc);

endmodule

`default_nettype wire

// File: logic/debug_top.sv
`timescale 1ns/1ns
`default_nettype none

module debug_top #(
  parameter int PROG_ADDR_WIDTH = 11
) (
  input  logic                             i_clock,
  input  logic                             i_reset,
  input  logic                             i_rx_done,
  input  logic [debug_pkg::BYTE_WIDTH-1:0] i_rx_data,
  input  logic                             i_soft_reset_ack,
  input  logic [debug_pkg::WORD_WIDTH-1:0] i_instruction,
  input  logic [debug_pkg::WORD_WIDTH-1:0] i_db_data,
  output logic                             o_tx_start,
  output logic [debug_pkg::BYTE_WIDTH-1:0] o_tx_data,
  output logic                             o_soft_reset,
  output logic                             o_prog_we,
  output logic [PROG_ADDR_WIDTH-1:0]       o_prog_addr,
  output logic [debug_pkg::WORD_WIDTH-1:0] o_prog_data,
  output logic                             o_enable_pc,
  output debug_pkg::db_sel_t               o_db_select
);
  import debug_pkg::*;

  logic                  ack_start;
  logic                  run_start;
  logic                  step_mode;
  logic                  run_done;
  logic                  ser_tx_start;
  logic [BYTE_WIDTH-1:0] ser_tx_data;

  load_if #(.PROG_ADDR_WIDTH(PROG_ADDR_WIDTH)) load_bus ();
  report_if report_bus ();

  debug_sequencer u_sequencer (
    .i_clock          (i_clock),
    .i_reset          (i_reset),
    .i_rx_done        (i_rx_done),
    .i_rx_data        (i_rx_data),
    .i_soft_reset_ack (i_soft_reset_ack),
    .o_soft_reset     (o_soft_reset),
    .o_ack_start      (ack_start),
    .o_run_start      (run_start),
    .o_step_mode      (step_mode),
    .i_run_done       (run_done),
    .lif              (load_bus),
    .rif              (report_bus)
  );

  program_loader #(.PROG_ADDR_WIDTH(PROG_ADDR_WIDTH)) u_loader (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .lif         (load_bus),
    .o_prog_we   (o_prog_we),
    .o_prog_addr (o_prog_addr),
    .o_prog_data (o_prog_data)
  );

  report_serializer u_serializer (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .rif           (report_bus),
    .i_db_data     (i_db_data),
    .i_instruction (i_instruction),
    .o_db_select   (o_db_select),
    .o_tx_start    (ser_tx_start),
    .o_tx_data     (ser_tx_data)
  );

  run_control u_run (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_start       (run_start),
    .i_step        (step_mode),
    .i_instruction (i_instruction),
    .o_enable_pc   (o_enable_pc),
    .o_done        (run_done)
  );

  // Handshake byte and report bytes never overlap.
  assign o_tx_start = ack_start | ser_tx_start;
  assign o_tx_data  = ack_start ? CMD_LOAD_ACK : ser_tx_data;

endmodule

`default_nettype wire

// File: sim/host_tasks.svh
`ifndef HOST_TASKS_SVH
`define HOST_TASKS_SVH

  //////////////////////////////////////////////////
  // Host side of the debug link.
  //////////////////////////////////////////////////
  task automatic wait_cycles(input int count);
    repeat (count) @(posedge i_clock);
  endtask

  // Data stays put through the falling edge of the done flag.
  task automatic send_byte(input logic [BYTE_WIDTH-1:0] value);
    @(posedge i_clock);
    i_rx_data <= value;
    i_rx_done <= 1'b1;
    @(posedge i_clock);
    i_rx_done <= 1'b0;
    wait_cycles(2); // Gap between UART bytes.
  endtask

  task automatic open_session();
    send_byte(CMD_LOAD);
    do @(posedge i_clock); while (o_soft_reset);
    wait_cycles(3); // Ack held back for a while.
    tx_expect.push_back(CMD_LOAD_ACK);
    i_soft_reset_ack <= 1'b0;
    do @(posedge i_clock); while (!o_soft_reset);
    i_soft_reset_ack <= 1'b1;
    send_byte(CMD_LOAD_ACK);
  endtask

  task automatic load_program(input int count);
    logic [WORD_WIDTH-1:0] prog_word;
    prog_expect.delete();
    write_count = 0;
    for (int i = 0; i < count; i++) begin
      prog_word = $urandom;
      if (prog_word == HALT_WORD) begin
        prog_word = 32'h1;
      end
      prog_expect.push_back(prog_word);
      for (int b = BYTES_PER_WORD - 1; b >= 0; b--) begin
        send_byte(prog_word[b*BYTE_WIDTH +: BYTE_WIDTH]); // MSB first.
      end
    end
    repeat (BYTES_PER_WORD) send_byte(8'h00); // Zero word ends the load.
    wait_cycles(4);
    assert (write_count == count) else flag_mismatch("o_prog_we count", write_count, count);
  endtask

  task automatic start_run(input logic [BYTE_WIDTH-1:0] command, input logic is_step);
    step_run     = is_step;
    pc_allowed   = 1'b1;
    enable_count = 0;
    send_byte(command);
  endtask

  // A nonzero wrong_at sends a bad ack before the right one at that byte.
  task automatic answer_report(input int wrong_at, input int run_cycles);
    logic [BYTE_WIDTH-1:0] expected [1:REPORT_BYTES];
    do @(posedge i_clock); while (o_db_select != sel_pc);
    pc_allowed = 1'b0;
    assert (enable_count == run_cycles)
      else flag_mismatch("o_enable_pc cycles", enable_count, run_cycles);
    for (int k = 1; k <= REPORT_BYTES; k++) begin
      expected[k] = expected_report_byte(k);
    end
    for (int k = 1; k <= REPORT_BYTES; k++) begin
      tx_expect.push_back(expected[k]);
      do @(posedge i_clock); while (!o_tx_start);
      if (k == wrong_at) begin
        send_byte(BYTE_WIDTH'(k * REPORT_ACK_STEP + 1));
        wait_cycles(12); // No byte may follow.
      end
      send_byte(BYTE_WIDTH'(k * REPORT_ACK_STEP));
    end
  endtask

`endif

// File: sim/debug_tb.sv
`timescale 1ns/1ns
`default_nettype none

module debug_tb;
  import debug_pkg::*;

  localparam int PROG_ADDR_WIDTH = 11;
  localparam int RESET_CYCLES    = 16;
  localparam int BYTE_CYCLES     = 4;  // One host byte with its gap.
  localparam int MAX_WORDS       = 6;
  localparam int MAX_RUN         = 12;
  localparam int SESSION_CYCLES  = 40 + (MAX_WORDS + 1) * BYTES_PER_WORD * BYTE_CYCLES
                                 + 2 * (MAX_RUN + REPORT_BYTES * (2 * BYTE_CYCLES + 4) + 40);
  localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + 3 * SESSION_CYCLES);

  logic                       i_clock;
  logic                       i_reset;
  logic                       i_rx_done;
  logic [BYTE_WIDTH-1:0]      i_rx_data;
  logic                       i_soft_reset_ack;
  logic [WORD_WIDTH-1:0]      i_instruction;
  logic [WORD_WIDTH-1:0]      i_db_data;
  logic                       o_tx_start;
  logic [BYTE_WIDTH-1:0]      o_tx_data;
  logic                       o_soft_reset;
  logic                       o_prog_we;
  logic [PROG_ADDR_WIDTH-1:0] o_prog_addr;
  logic [WORD_WIDTH-1:0]      o_prog_data;
  logic                       o_enable_pc;
  db_sel_t                    o_db_select;

  logic [WORD_WIDTH-1:0] cpu_pc;
  logic [WORD_WIDTH-1:0] cpu_cycles;
  int                    run_left;         // Enabled cycles until HALT.
  logic                  pc_allowed;       // A run is under way.
  logic                  step_run;
  int                    run_len;
  int                    enable_count = 0;
  int                    write_count  = 0;
  int                    tx_count     = 0;
  int                    error_count  = 0;
  logic [BYTE_WIDTH-1:0] tx_expect[$];
  logic [WORD_WIDTH-1:0] prog_expect[$];
  logic [BYTE_WIDTH-1:0] tx_next;

  debug_top #(.PROG_ADDR_WIDTH(PROG_ADDR_WIDTH)) UUT (.*);

  initial begin
    i_clock = 1'b0;
    forever #2 i_clock = ~i_clock;
  end

  //////////////////////////////////////////////////
  // CPU model.
  //////////////////////////////////////////////////
  always @(posedge i_clock) begin
    if (o_enable_pc) begin
      enable_count = enable_count + 1;
      cpu_pc     <= cpu_pc + 32'd4;
      cpu_cycles <= cpu_cycles + 32'd1;
      if (run_left <= 1) begin
        run_left      <= 0;
        i_instruction <= HALT_WORD;
      end else begin
        run_left      <= run_left - 1;
        i_instruction <= $urandom | 32'h1; // Any opcode but HALT.
      end
    end
  end

  always_comb begin
    case (o_db_select)
      sel_pc:          i_db_data = cpu_pc;
      sel_cycles:      i_db_data = cpu_cycles;
      sel_adder_pc:    i_db_data = cpu_pc + 32'd4;
      sel_instruction: i_db_data = i_instruction;
      default:         i_db_data = 32'hffff_ffff;
    endcase
  end

  //////////////////////////////////////////////////
  // Checks.
  //////////////////////////////////////////////////
  task automatic flag_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    $display("Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, want);
    error_count = error_count + 1;
  endtask

  task automatic flag_failure(input string what);
    $display("Failure at %0t ns: %s", $time, what);
    error_count = error_count + 1;
  endtask

  task automatic check_reset_outputs();
    assert (!o_tx_start) else flag_mismatch("o_tx_start", o_tx_start, 0);
    assert (!o_prog_we) else flag_mismatch("o_prog_we", o_prog_we, 0);
    assert (!o_enable_pc) else flag_mismatch("o_enable_pc", o_enable_pc, 0);
    assert (o_soft_reset) else flag_mismatch("o_soft_reset", o_soft_reset, 1);
    assert (o_db_select == sel_none)
      else flag_mismatch("o_db_select", 32'(o_db_select), 32'(sel_none));
  endtask

  // Report order is PC, cycles, adder PC (low halves) then the whole instruction.
  function automatic logic [BYTE_WIDTH-1:0] expected_report_byte(input int k);
    logic [WORD_WIDTH-1:0] adder_pc;
    adder_pc = cpu_pc + 32'd4;
    case (k)
      1:       return cpu_pc[15:8];
      2:       return cpu_pc[7:0];
      3:       return cpu_cycles[15:8];
      4:       return cpu_cycles[7:0];
      5:       return adder_pc[15:8];
      6:       return adder_pc[7:0];
      7:       return i_instruction[31:24];
      8:       return i_instruction[23:16];
      9:       return i_instruction[15:8];
      default: return i_instruction[7:0];
    endcase
  endfunction

  always @(posedge i_clock) begin
    if (i_reset && o_tx_start) begin
      tx_count = tx_count + 1;
      if (tx_expect.size() == 0) begin
        flag_failure("tx strobe while no byte was expected");
      end else begin
        tx_next = tx_expect.pop_front();
        assert (o_tx_data == tx_next) else flag_mismatch("o_tx_data", o_tx_data, tx_next);
      end
    end
  end

  always @(posedge i_clock) begin
    if (i_reset && o_prog_we) begin
      if (write_count >= prog_expect.size()) begin
        flag_failure("program write after the last nonzero word");
      end else begin
        assert (o_prog_addr == write_count)
          else flag_mismatch("o_prog_addr", o_prog_addr, write_count);
        assert (o_prog_data == prog_expect[write_count])
          else flag_mismatch("o_prog_data", o_prog_data, prog_expect[write_count]);
      end
      write_count = write_count + 1;
    end
  end

  a_tx_single: assert property (@(posedge i_clock) disable iff (!i_reset)
    o_tx_start |=> !o_tx_start) else flag_failure("tx strobe longer than one cycle");
  a_reset_held: assert property (@(posedge i_clock) disable iff (!i_reset)
    !o_soft_reset && i_soft_reset_ack |=> !o_soft_reset)
    else flag_failure("o_soft_reset released before the acknowledge");
  a_ack_byte: assert property (@(posedge i_clock) disable iff (!i_reset)
    !o_soft_reset && !i_soft_reset_ack |=> o_tx_start && o_soft_reset)
    else flag_failure("no tx strobe right after the soft reset acknowledge");
  a_enable_allowed: assert property (@(posedge i_clock) disable iff (!i_reset)
    o_enable_pc |-> pc_allowed) else flag_failure("o_enable_pc high outside a run");
  a_halt_stops: assert property (@(posedge i_clock) disable iff (!i_reset)
    o_enable_pc && !step_run |-> i_instruction != HALT_WORD)
    else flag_failure("o_enable_pc high while HALT is fetched");
  a_enable_held: assert property (@(posedge i_clock) disable iff (!i_reset)
    o_enable_pc && !step_run |=> o_enable_pc || i_instruction == HALT_WORD)
    else flag_failure("o_enable_pc dropped before HALT was fetched");

  `include "host_tasks.svh"

  task automatic arm_cpu(input int length);
    @(posedge i_clock);
    run_left      <= length;
    i_instruction <= $urandom | 32'h1;
  endtask

  task automatic print_summary();
    $display("Summary: %0d tx bytes checked, %0d errors", tx_count, error_count);
  endtask

  //////////////////////////////////////////////////
  // Test sequence.
  //////////////////////////////////////////////////
  initial begin
    void'($urandom(67));
    i_reset          = 1'b0;
    i_rx_done        = 1'b0;
    i_rx_data        = '0;
    i_soft_reset_ack = 1'b1;
    i_instruction    = HALT_WORD;
    cpu_pc           = $urandom & 32'h0000_fffc;
    cpu_cycles       = $urandom & 32'h0000_ffff;
    run_left         = 0;
    pc_allowed       = 1'b0;
    step_run         = 1'b0;
    repeat (RESET_CYCLES / 2) @(posedge i_clock);
    check_reset_outputs();
    repeat (RESET_CYCLES / 2) @(posedge i_clock);
    i_reset <= 1'b1;
    wait_cycles(4);
    check_reset_outputs();

    open_session(); // Continuous run.
    load_program(5);
    run_len = 3 + int'($urandom % (MAX_RUN - 2));
    arm_cpu(run_len);
    start_run(CMD_RUN, 1'b0);
    answer_report(0, run_len);

    open_session(); // Two steps, the second one lands on HALT.
    load_program(3);
    arm_cpu(2);
    start_run(CMD_STEP, 1'b1);
    answer_report(4, 1);
    start_run(CMD_STEP, 1'b1);
    answer_report(0, 1);
    send_byte(CMD_STEP); // Idle now, so nothing may move.
    wait_cycles(20);

    open_session();
    load_program(2);
    run_len = 3 + int'($urandom % (MAX_RUN - 2));
    arm_cpu(run_len);
    start_run(CMD_RUN, 1'b0);
    answer_report(0, run_len);
    wait_cycles(10);

    print_summary();
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge i_clock);
    $display("Timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
    print_summary();
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+sim
logic/debug_pkg.sv
logic/load_if.sv
logic/report_if.sv
logic/debug_sequencer.sv
logic/program_loader.sv
logic/report_serializer.sv
logic/run_control.sv
logic/debug_top.sv
sim/debug_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module debug_tb -f sim.f \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/Vdebug_tb > sim.log 2>&1 || echo "Simulator exited with an error status"
cat sim.log
grep -q "Done: errors found" sim.log && { echo "FAIL"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "FAIL: no pass message in sim.log"; exit 1; }
echo "PASS"
